// File: hdl/cce_defs.svh
/*
  Widths and sizes for the microcoded CCE
  Microcode store, register file, address and LCE id widths,
  and the pending table geometry
*/
`ifndef CCE_DEFS_SVH
`define CCE_DEFS_SVH

// Microcode store
`define CCE_PC_WIDTH 8
`define CCE_INSTR_WIDTH 32

// General registers
`define CCE_GPR_WIDTH 16
`define CCE_NUM_GPR 4

// Coherence messages
`define CCE_PADDR_WIDTH 16
`define CCE_LCE_ID_WIDTH 4

// 64 byte blocks, way group index sits just above
`define CCE_BLOCK_OFFSET 6
`define CCE_NUM_WAY_GROUPS 16

`endif

// File: hdl/cce_pkg.sv
/*
  CCE types
  Opcode and LCE command enums, the instruction word as a union
  with alu and msg views, and the decoded control word
*/
`include "cce_defs.svh"

package cce_pkg;

  typedef enum logic [3:0] {
    NOP   = 4'd0,
    MOVI  = 4'd1,
    ADD   = 4'd2,
    ADDI  = 4'd3,
    AND   = 4'd4,
    BEQ   = 4'd5,
    BI    = 4'd6,
    POPQ  = 4'd7,
    PUSHQ = 4'd8,
    PENDW = 4'd9,
    PENDR = 4'd10
  } cce_op_e;

  typedef enum logic [1:0] {
    SET_STATE  = 2'd0,
    INVALIDATE = 2'd1,
    TRANSFER   = 2'd2,
    WRITEBACK  = 2'd3
  } cce_lce_cmd_e;

  typedef logic [$clog2(`CCE_NUM_GPR)-1:0] cce_gpr_sel_t;

  // ALU and branch format
  typedef struct packed {
    cce_op_e                   op;
    cce_gpr_sel_t              dst;
    cce_gpr_sel_t              src_a;
    cce_gpr_sel_t              src_b;
    logic [5:0]                pad;
    logic [`CCE_GPR_WIDTH-1:0] imm;
  } cce_alu_inst_s;

  // Queue and pending bit format
  typedef struct packed {
    cce_op_e      op;
    cce_gpr_sel_t dst;
    cce_gpr_sel_t src_a;
    logic         pv;
    cce_lce_cmd_e cmd_type;
    logic [20:0]  pad;
  } cce_msg_inst_s;

  typedef union packed {
    cce_alu_inst_s alu;
    cce_msg_inst_s msg;
  } cce_inst_u;

  typedef struct packed {
    cce_op_e                   op;
    cce_gpr_sel_t              dst;
    cce_gpr_sel_t              src_a;
    cce_gpr_sel_t              src_b;
    logic [`CCE_GPR_WIDTH-1:0] imm;
    logic                      gpr_w_v;
    logic                      alu_v;
    logic                      branch;
    logic                      branch_uncond;
    logic                      popq_v;
    logic                      pushq_v;
    logic                      pend_w_v;
    logic                      pend_r_v;
    logic                      pend_val;
    cce_lce_cmd_e              cmd_type;
  } cce_decoded_s;

endpackage

// File: hdl/cce_inst_ram.sv
/*
  Microcode RAM and fetch stage
  Synchronous program and readback port, fetch PC and
  static predecode of unconditional branches
*/
`timescale 1ns/1ps
`include "cce_defs.svh"

module cce_inst_ram (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         mode_i,
  input  logic                         stall_i,
  input  logic                         mispredict_i,
  input  logic [`CCE_PC_WIDTH-1:0]     branch_pc_i,
  input  logic                         ucode_v_i,
  input  logic                         ucode_w_i,
  input  logic [`CCE_PC_WIDTH-1:0]     ucode_addr_i,
  input  logic [`CCE_INSTR_WIDTH-1:0]  ucode_data_i,
  output logic [`CCE_INSTR_WIDTH-1:0]  ucode_data_o,
  output cce_pkg::cce_inst_u           inst_o,
  output logic [`CCE_PC_WIDTH-1:0]     inst_pc_o,
  output logic                         inst_v_o
);
  import cce_pkg::*;

  localparam int ram_depth = 2 ** `CCE_PC_WIDTH;

  logic [`CCE_INSTR_WIDTH-1:0] mem [ram_depth];
  logic [`CCE_INSTR_WIDTH-1:0] rdata_r;
  logic [`CCE_PC_WIDTH-1:0]    pc_r, next_pc, ram_addr;
  logic                        inst_v_r, ram_re, ram_we;

  // Predecode: BI is taken here, BEQ falls through
  always_comb begin
    if (mispredict_i) begin
      next_pc = branch_pc_i;
    end else if (!inst_v_r) begin
      next_pc = '0;
    end else if (inst_o.alu.op == BI) begin
      next_pc = inst_o.alu.imm[`CCE_PC_WIDTH-1:0];
    end else begin
      next_pc = pc_r + 1'b1;
    end
  end

  // Program port owns the RAM in program mode
  assign ram_addr = mode_i ? next_pc : ucode_addr_i;
  assign ram_re   = mode_i ? !stall_i : ucode_v_i;
  assign ram_we   = !mode_i && ucode_v_i && ucode_w_i;

  always_ff @(posedge clk_i) begin
    if (ram_we) mem[ram_addr] <= ucode_data_i;
    if (ram_re) rdata_r <= mem[ram_addr];
  end

  // pc_r is the address of the word in rdata_r
  always_ff @(posedge clk_i) begin
    if (reset_i || !mode_i) begin
      pc_r     <= '0;
      inst_v_r <= 1'b0;
    end else if (!stall_i) begin
      pc_r     <= next_pc;
      inst_v_r <= 1'b1;
    end
  end

  assign ucode_data_o = rdata_r;
  assign inst_o       = rdata_r;
  assign inst_pc_o    = pc_r;
  assign inst_v_o     = inst_v_r;

  // Microcode must not change under a running program
  a_no_run_write: assert property (@(posedge clk_i) disable iff (reset_i)
    mode_i |-> !(ucode_v_i && ucode_w_i));

endmodule

// File: hdl/cce_inst_decode.sv
/*
  Decode register
  Splits the instruction word through its alu or msg view,
  holds on stall and flushes to NOP on mispredict
*/
`timescale 1ns/1ps
`include "cce_defs.svh"

module cce_inst_decode (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     mode_i,
  input  logic                     stall_i,
  input  logic                     mispredict_i,
  input  cce_pkg::cce_inst_u       inst_i,
  input  logic [`CCE_PC_WIDTH-1:0] inst_pc_i,
  input  logic                     inst_v_i,
  output cce_pkg::cce_decoded_s    decoded_o,
  output logic [`CCE_PC_WIDTH-1:0] pc_o
);
  import cce_pkg::*;

  cce_decoded_s dec;

  always_comb begin
    dec    = '0;
    dec.op = inst_i.alu.op;
    case (inst_i.alu.op)
      MOVI, ADD, ADDI, AND, BEQ, BI: begin
        dec.dst           = inst_i.alu.dst;
        dec.src_a         = inst_i.alu.src_a;
        dec.src_b         = inst_i.alu.src_b;
        dec.imm           = inst_i.alu.imm;
        dec.alu_v         = !(inst_i.alu.op inside {BEQ, BI});
        dec.gpr_w_v       = dec.alu_v;
        dec.branch        = inst_i.alu.op inside {BEQ, BI};
        dec.branch_uncond = inst_i.alu.op == BI;
      end
      POPQ, PUSHQ, PENDW, PENDR: begin
        dec.dst      = inst_i.msg.dst;
        dec.src_a    = inst_i.msg.src_a;
        dec.popq_v   = inst_i.msg.op == POPQ;
        dec.pushq_v  = inst_i.msg.op == PUSHQ;
        dec.pend_w_v = inst_i.msg.op == PENDW;
        dec.pend_r_v = inst_i.msg.op == PENDR;
        dec.gpr_w_v  = inst_i.msg.op inside {POPQ, PENDR};
        dec.pend_val = inst_i.msg.pv;
        dec.cmd_type = inst_i.msg.cmd_type;
      end
      default: dec.op = NOP;
    endcase
  end

  // An all-zero control word is a NOP
  always_ff @(posedge clk_i) begin
    if (reset_i || !mode_i || mispredict_i) begin
      decoded_o <= '0;
    end else if (!stall_i) begin
      decoded_o <= inst_v_i ? dec : '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall_i) pc_o <= inst_pc_i;
  end

endmodule

// File: hdl/cce_exec.sv
/*
  Execute stage
  General registers, ALU, BEQ resolution,
  pending table access and register writeback
*/
`timescale 1ns/1ps
`include "cce_defs.svh"

module cce_exec (
  input  logic                         clk_i,
  input  logic                         stall_i,
  input  cce_pkg::cce_decoded_s        decoded_i,
  input  logic [`CCE_PC_WIDTH-1:0]     pc_i,
  input  logic                         pending_i,
  input  logic [`CCE_PADDR_WIDTH-1:0]  popq_addr_i,
  output logic [`CCE_GPR_WIDTH-1:0]    src_a_o,
  output logic                         mispredict_o,
  output logic [`CCE_PC_WIDTH-1:0]     branch_pc_o,
  output logic                         pend_w_v_o,
  output logic                         pend_r_v_o,
  output logic [`CCE_PADDR_WIDTH-1:0]  pend_addr_o,
  output logic                         pend_val_o
);
  import cce_pkg::*;

  logic [`CCE_GPR_WIDTH-1:0] gpr_r [`CCE_NUM_GPR];
  logic [`CCE_GPR_WIDTH-1:0] src_a, src_b, alu_res, wb_data;

  assign src_a = gpr_r[decoded_i.src_a];
  assign src_b = gpr_r[decoded_i.src_b];

  always_comb begin
    case (decoded_i.op)
      MOVI:    alu_res = decoded_i.imm;
      ADD:     alu_res = src_a + src_b;
      ADDI:    alu_res = src_a + decoded_i.imm;
      AND:     alu_res = src_a & src_b;
      default: alu_res = '0;
    endcase
  end

  // BEQ was predicted not taken; a taken branch to pc+1 needs no flush
  assign branch_pc_o  = decoded_i.imm[`CCE_PC_WIDTH-1:0];
  assign mispredict_o = decoded_i.branch && !decoded_i.branch_uncond &&
                        (src_a == src_b) && (branch_pc_o != pc_i + 1'b1);

  // Pending table uses src_a as the block address
  assign pend_w_v_o  = decoded_i.pend_w_v && !stall_i;
  assign pend_r_v_o  = decoded_i.pend_r_v;
  assign pend_addr_o = src_a;
  assign pend_val_o  = decoded_i.pend_val;
  assign src_a_o     = src_a;

  always_comb begin
    if (decoded_i.alu_v) begin
      wb_data = alu_res;
    end else if (decoded_i.popq_v) begin
      wb_data = popq_addr_i;
    end else begin
      wb_data = {{(`CCE_GPR_WIDTH-1){1'b0}}, pending_i};
    end
  end

  always_ff @(posedge clk_i) begin
    if (decoded_i.gpr_w_v && !stall_i) begin
      gpr_r[decoded_i.dst] <= wb_data;
    end
  end

endmodule

// File: hdl/cce_pending_bits.sv
/*
  Pending bit table
  One bit per way group, synchronous write, combinational read
*/
`timescale 1ns/1ps
`include "cce_defs.svh"

module cce_pending_bits (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        w_v_i,
  input  logic                        r_v_i,
  input  logic [`CCE_PADDR_WIDTH-1:0] addr_i,
  input  logic                        val_i,
  output logic                        pending_o
);
  import cce_pkg::*;

  localparam int wg_width = $clog2(`CCE_NUM_WAY_GROUPS);

  logic [`CCE_NUM_WAY_GROUPS-1:0] bits_r;
  logic [wg_width-1:0]            wg;

  // Way group index sits just above the block offset
  assign wg = addr_i[`CCE_BLOCK_OFFSET +: wg_width];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      bits_r <= '0;
    end else if (w_v_i) begin
      bits_r[wg] <= val_i;
    end
  end

  assign pending_o = r_v_i && bits_r[wg];

  a_one_access: assert property (@(posedge clk_i) disable iff (reset_i)
    !(w_v_i && r_v_i));

endmodule

// File: hdl/cce_msg.sv
/*
  Message unit
  Pops LCE requests, pushes LCE commands from a registered output,
  keeps the requesting LCE id and raises the pipeline stall
*/
`timescale 1ns/1ps
`include "cce_defs.svh"

module cce_msg (
  input  logic                                          clk_i,
  input  logic                                          reset_i,
  input  cce_pkg::cce_decoded_s                         decoded_i,
  input  logic [`CCE_GPR_WIDTH-1:0]                     src_a_i,
  input  logic [`CCE_LCE_ID_WIDTH+`CCE_PADDR_WIDTH-1:0] lce_req_i,
  input  logic                                          lce_req_v_i,
  output logic                                          lce_req_yumi_o,
  output logic [$bits(cce_pkg::cce_lce_cmd_e)+`CCE_LCE_ID_WIDTH+`CCE_PADDR_WIDTH-1:0] lce_cmd_o,
  output logic                                          lce_cmd_v_o,
  input  logic                                          lce_cmd_ready_i,
  output logic [`CCE_PADDR_WIDTH-1:0]                   popq_addr_o,
  output logic                                          stall_o
);
  import cce_pkg::*;

  logic [`CCE_LCE_ID_WIDTH-1:0] req_lce_r;
  logic                         popq_stall, pushq_stall, pushq_fire;

  // POPQ waits for a request
  assign popq_stall     = decoded_i.popq_v && !lce_req_v_i;
  assign lce_req_yumi_o = decoded_i.popq_v && lce_req_v_i;
  assign popq_addr_o    = lce_req_i[`CCE_PADDR_WIDTH-1:0];

  // PUSHQ waits while the held command is not taken
  assign pushq_stall = decoded_i.pushq_v && lce_cmd_v_o && !lce_cmd_ready_i;
  assign pushq_fire  = decoded_i.pushq_v && !pushq_stall;

  assign stall_o = popq_stall || pushq_stall;

  // Requesting LCE, used by later commands
  always_ff @(posedge clk_i) begin
    if (lce_req_yumi_o) begin
      req_lce_r <= lce_req_i[`CCE_PADDR_WIDTH +: `CCE_LCE_ID_WIDTH];
    end
  end

  always_ff @(posedge clk_i) begin
    if (pushq_fire) begin
      lce_cmd_o <= {decoded_i.cmd_type, req_lce_r, src_a_i};
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lce_cmd_v_o <= 1'b0;
    end else if (pushq_fire) begin
      lce_cmd_v_o <= 1'b1;
    end else if (lce_cmd_ready_i) begin
      lce_cmd_v_o <= 1'b0;
    end
  end

  // Held command must not change before the consumer takes it
  a_cmd_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    (lce_cmd_v_o && !lce_cmd_ready_i) |=> (lce_cmd_v_o && $stable(lce_cmd_o)));

endmodule

// File: hdl/cce_top.sv
/*
  CCE top level
  Fetch with microcode RAM, decode register, execute,
  pending bit table and message unit
*/
`timescale 1ns/1ps
`include "cce_defs.svh"

module cce_top (
  input  logic                                          clk_i,
  input  logic                                          reset_i,
  input  logic                                          mode_i,
  input  logic                                          ucode_v_i,
  input  logic                                          ucode_w_i,
  input  logic [`CCE_PC_WIDTH-1:0]                      ucode_addr_i,
  input  logic [`CCE_INSTR_WIDTH-1:0]                   ucode_data_i,
  output logic [`CCE_INSTR_WIDTH-1:0]                   ucode_data_o,
  input  logic [`CCE_LCE_ID_WIDTH+`CCE_PADDR_WIDTH-1:0] lce_req_i,
  input  logic                                          lce_req_v_i,
  output logic                                          lce_req_yumi_o,
  output logic [$bits(cce_pkg::cce_lce_cmd_e)+`CCE_LCE_ID_WIDTH+`CCE_PADDR_WIDTH-1:0] lce_cmd_o,
  output logic                                          lce_cmd_v_o,
  input  logic                                          lce_cmd_ready_i
);
  import cce_pkg::*;

  // Fetch to decode
  cce_inst_u                  fetch_inst;
  logic [`CCE_PC_WIDTH-1:0]   fetch_pc;
  logic                       fetch_v;

  // Decode to execute
  cce_decoded_s               decoded;
  logic [`CCE_PC_WIDTH-1:0]   ex_pc;

  // Branch resolution and stall
  logic                       mispredict;
  logic [`CCE_PC_WIDTH-1:0]   branch_pc;
  logic                       stall;

  // Execute to pending table and message unit
  logic                       pend_w_v, pend_r_v, pend_val, pending;
  logic [`CCE_PADDR_WIDTH-1:0] pend_addr;
  logic [`CCE_GPR_WIDTH-1:0]  src_a;
  logic [`CCE_PADDR_WIDTH-1:0] popq_addr;

  cce_inst_ram inst_ram (
    .clk_i(clk_i), .reset_i(reset_i), .mode_i(mode_i),
    .stall_i(stall), .mispredict_i(mispredict), .branch_pc_i(branch_pc),
    .ucode_v_i(ucode_v_i), .ucode_w_i(ucode_w_i), .ucode_addr_i(ucode_addr_i),
    .ucode_data_i(ucode_data_i), .ucode_data_o(ucode_data_o),
    .inst_o(fetch_inst), .inst_pc_o(fetch_pc), .inst_v_o(fetch_v)
  );

  cce_inst_decode inst_decode (
    .clk_i(clk_i), .reset_i(reset_i), .mode_i(mode_i),
    .stall_i(stall), .mispredict_i(mispredict),
    .inst_i(fetch_inst), .inst_pc_i(fetch_pc), .inst_v_i(fetch_v),
    .decoded_o(decoded), .pc_o(ex_pc)
  );

  cce_exec exec (
    .clk_i(clk_i), .stall_i(stall), .decoded_i(decoded), .pc_i(ex_pc),
    .pending_i(pending), .popq_addr_i(popq_addr), .src_a_o(src_a),
    .mispredict_o(mispredict), .branch_pc_o(branch_pc),
    .pend_w_v_o(pend_w_v), .pend_r_v_o(pend_r_v),
    .pend_addr_o(pend_addr), .pend_val_o(pend_val)
  );

  cce_pending_bits pending_bits (
    .clk_i(clk_i), .reset_i(reset_i), .w_v_i(pend_w_v), .r_v_i(pend_r_v),
    .addr_i(pend_addr), .val_i(pend_val), .pending_o(pending)
  );

  cce_msg message (
    .clk_i(clk_i), .reset_i(reset_i), .decoded_i(decoded), .src_a_i(src_a),
    .lce_req_i(lce_req_i), .lce_req_v_i(lce_req_v_i), .lce_req_yumi_o(lce_req_yumi_o),
    .lce_cmd_o(lce_cmd_o), .lce_cmd_v_o(lce_cmd_v_o), .lce_cmd_ready_i(lce_cmd_ready_i),
    .popq_addr_o(popq_addr), .stall_o(stall)
  );

endmodule

// File: test/tb_cce.sv
/*
  Directed testbench for the CCE
  Program loader, request driver, command monitor,
  one task per test and a watchdog
*/
`timescale 1ns/1ps
`include "cce_defs.svh"

module tb_cce;
  import cce_pkg::*;

  localparam int period = 100;
  localparam int seed_init = 94697;
  localparam int wait_limit = 200;
  localparam int max_prog = 32;
  // Six tests, each bounded by loading plus waiting, plus margin
  localparam int watchdog_cycles = 6 * (max_prog + wait_limit + 150) + 500;

  logic clk_i = 1'b0, reset_i, mode_i, ucode_v_i, ucode_w_i;
  logic [`CCE_PC_WIDTH-1:0] ucode_addr_i;
  logic [`CCE_INSTR_WIDTH-1:0] ucode_data_i, ucode_data_o;
  logic [19:0] lce_req_i;
  logic lce_req_v_i, lce_req_yumi_o, lce_cmd_v_o, lce_cmd_ready_i;
  logic [21:0] lce_cmd_o;

  int seed = seed_init;
  int err_cnt = 0;
  int yumi_cnt = 0;
  logic [21:0] cmd_q[$];
  logic [31:0] prog_q[$];
  logic [3:0] last_id;
  logic held_v = 1'b0;
  logic [21:0] held_cmd;
  logic bp_on = 1'b0;

  cce_top dut0 (.*);

  always #(period / 2) clk_i = ~clk_i;

  // Accepted commands, yumi count and hold stability
  always @(posedge clk_i) begin
    if (!reset_i) begin
      if (held_v) begin
        assert (lce_cmd_v_o && lce_cmd_o == held_cmd) else begin
          $display("Command changed or dropped while it was held");
          err_cnt++;
        end
      end
      held_v = lce_cmd_v_o && !lce_cmd_ready_i;
      held_cmd = lce_cmd_o;
      if (lce_cmd_v_o && lce_cmd_ready_i) cmd_q.push_back(lce_cmd_o);
      if (lce_req_yumi_o) yumi_cnt++;
    end
  end

  function automatic logic [31:0] alu_word(cce_op_e op, int dst, int a, int b,
                                           logic [15:0] imm);
    return {op, dst[1:0], a[1:0], b[1:0], 6'b0, imm};
  endfunction

  function automatic logic [31:0] msg_word(cce_op_e op, int dst, int a, logic pv,
                                           cce_lce_cmd_e ct);
    return {op, dst[1:0], a[1:0], pv, ct, 21'b0};
  endfunction

  function automatic logic [15:0] rnd16();
    int r;
    r = $random(seed);
    return r[15:0];
  endfunction

  task automatic check_val(string name, logic [31:0] exp, logic [31:0] act);
    assert (exp == act) else begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      err_cnt++;
    end
  endtask

  // Program mode, write prog_q from address 0, then run mode
  task automatic load_prog();
    @(negedge clk_i);
    mode_i = 1'b0;
    cmd_q.delete();
    yumi_cnt = 0;
    foreach (prog_q[i]) begin
      @(negedge clk_i);
      ucode_v_i = 1'b1;
      ucode_w_i = 1'b1;
      ucode_addr_i = i[7:0];
      ucode_data_i = prog_q[i];
    end
    @(negedge clk_i);
    ucode_v_i = 1'b0;
    ucode_w_i = 1'b0;
    mode_i = 1'b1;
  endtask

  task automatic send_req(logic [3:0] id, logic [15:0] addr);
    @(negedge clk_i);
    lce_req_v_i = 1'b1;
    lce_req_i = {id, addr};
    do @(posedge clk_i); while (!lce_req_yumi_o);
    last_id = id;
    @(negedge clk_i);
    lce_req_v_i = 1'b0;
  endtask

  task automatic wait_cmds(string name, int n);
    int waited = 0;
    while (cmd_q.size() < n && waited < wait_limit) begin
      @(negedge clk_i);
      waited++;
    end
    if (cmd_q.size() < n) begin
      $display("%s timed out waiting for %0d commands, got %0d", name, n, cmd_q.size());
      err_cnt++;
    end
    repeat (10) @(negedge clk_i);
    check_val({name, " count"}, n, cmd_q.size());
  endtask

  task automatic check_cmd(string name, int i, cce_lce_cmd_e ct, logic [15:0] addr);
    if (i < cmd_q.size()) check_val(name, {ct, last_id, addr}, cmd_q[i]);
  endtask

  task automatic test_readback();
    logic [31:0] model [256];
    logic [7:0] addrs[$];
    logic [7:0] a;
    logic [15:0] r;
    mode_i = 1'b0;
    for (int i = 0; i < 24; i++) begin
      r = rnd16();
      a = r[7:0];
      model[a] = {rnd16(), rnd16()};
      addrs.push_back(a);
      @(negedge clk_i);
      ucode_v_i = 1'b1;
      ucode_w_i = 1'b1;
      ucode_addr_i = a;
      ucode_data_i = model[a];
    end
    foreach (addrs[i]) begin
      @(negedge clk_i);
      ucode_w_i = 1'b0;
      ucode_v_i = 1'b1;
      ucode_addr_i = addrs[i];
      @(negedge clk_i);
      ucode_v_i = 1'b0;
      check_val("readback", model[addrs[i]], ucode_data_o);
    end
  endtask

  task automatic test_alu();
    logic [15:0] x = rnd16(), y = rnd16(), z = rnd16(), w = rnd16();
    prog_q = '{msg_word(POPQ, 0, 0, 0, SET_STATE), alu_word(MOVI, 1, 0, 0, x),
               alu_word(MOVI, 2, 0, 0, y), alu_word(ADD, 3, 1, 2, 0),
               msg_word(PUSHQ, 0, 3, 0, INVALIDATE), alu_word(ADDI, 3, 1, 0, z),
               msg_word(PUSHQ, 0, 3, 0, TRANSFER), alu_word(AND, 3, 1, 2, 0),
               msg_word(PUSHQ, 0, 3, 0, WRITEBACK), alu_word(MOVI, 3, 0, 0, w),
               msg_word(PUSHQ, 0, 3, 0, SET_STATE), alu_word(BI, 0, 0, 0, 11)};
    load_prog();
    send_req(4'hA, rnd16());
    wait_cmds("alu", 4);
    check_cmd("alu add", 0, INVALIDATE, x + y);
    check_cmd("alu addi", 1, TRANSFER, x + z);
    check_cmd("alu and", 2, WRITEBACK, x & y);
    check_cmd("alu movi", 3, SET_STATE, w);
  endtask

  task automatic test_branch();
    prog_q = '{alu_word(MOVI, 3, 0, 0, 16'hDEAD), alu_word(MOVI, 1, 0, 0, 5),
               alu_word(MOVI, 2, 0, 0, 5), alu_word(BEQ, 0, 1, 2, 5),
               msg_word(PUSHQ, 0, 3, 0, TRANSFER), alu_word(MOVI, 2, 0, 0, 6),
               alu_word(BEQ, 0, 1, 2, 4), msg_word(PUSHQ, 0, 1, 0, TRANSFER),
               alu_word(MOVI, 0, 0, 0, 0), alu_word(MOVI, 2, 0, 0, 3),
               alu_word(ADDI, 0, 0, 0, 1), alu_word(BEQ, 0, 0, 2, 13),
               alu_word(BI, 0, 0, 0, 10), msg_word(PUSHQ, 0, 0, 0, TRANSFER),
               alu_word(BI, 0, 0, 0, 14)};
    load_prog();
    wait_cmds("branch", 2);
    check_cmd("branch fallthrough", 0, TRANSFER, 16'd5);
    check_cmd("branch loop", 1, TRANSFER, 16'd3);
  endtask

  // POPQ then PUSHQ in a loop gives one command per request
  task automatic test_requests(string name, int n);
    logic [3:0] ids[$];
    logic [15:0] addrs[$];
    logic [15:0] r;
    prog_q = '{msg_word(POPQ, 0, 0, 0, SET_STATE), msg_word(PUSHQ, 0, 0, 0, WRITEBACK),
               alu_word(BI, 0, 0, 0, 0)};
    load_prog();
    for (int i = 0; i < n; i++) begin
      repeat (rnd16() % 4) @(negedge clk_i);
      r = rnd16();
      ids.push_back(r[3:0]);
      addrs.push_back(rnd16());
      send_req(ids[i], addrs[i]);
    end
    wait_cmds(name, n);
    check_val({name, " yumi"}, n, yumi_cnt);
    foreach (ids[i]) begin
      if (i < cmd_q.size()) check_val(name, {WRITEBACK, ids[i], addrs[i]}, cmd_q[i]);
    end
  endtask

  task automatic test_backpressure();
    int r;
    bp_on = 1'b1;
    fork
      while (bp_on) begin
        @(negedge clk_i);
        r = $random(seed);
        lce_cmd_ready_i = bp_on ? r[0] : 1'b1;
      end
    join_none
    test_requests("backpressure", 10);
    bp_on = 1'b0;
    repeat (3) @(negedge clk_i);
  endtask

  task automatic test_pending();
    logic [15:0] a = 16'h1240;
    prog_q = '{alu_word(MOVI, 1, 0, 0, a), alu_word(MOVI, 2, 0, 0, a ^ 16'h4013),
               alu_word(MOVI, 3, 0, 0, a ^ 16'h0040), msg_word(PENDW, 0, 1, 1, SET_STATE),
               msg_word(PENDR, 0, 2, 0, SET_STATE), msg_word(PUSHQ, 0, 0, 0, SET_STATE),
               msg_word(PENDR, 0, 3, 0, SET_STATE), msg_word(PUSHQ, 0, 0, 0, SET_STATE),
               msg_word(PENDW, 0, 1, 0, SET_STATE), msg_word(PENDR, 0, 2, 0, SET_STATE),
               msg_word(PUSHQ, 0, 0, 0, SET_STATE), alu_word(BI, 0, 0, 0, 11)};
    load_prog();
    wait_cmds("pending", 3);
    check_cmd("pending same group", 0, SET_STATE, 16'd1);
    check_cmd("pending other group", 1, SET_STATE, 16'd0);
    check_cmd("pending cleared", 2, SET_STATE, 16'd0);
  endtask

  initial begin
    #(watchdog_cycles * period);
    $display("Watchdog expired before the tests finished");
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    reset_i = 1'b1;
    mode_i = 1'b0;
    ucode_v_i = 1'b0;
    ucode_w_i = 1'b0;
    ucode_addr_i = '0;
    ucode_data_i = '0;
    lce_req_i = '0;
    lce_req_v_i = 1'b0;
    lce_cmd_ready_i = 1'b1;
    last_id = '0;
    repeat (5) @(negedge clk_i);
    reset_i = 1'b0;
    test_readback();
    test_alu();
    test_branch();
    test_requests("request", 6);
    test_backpressure();
    test_pending();
    $display("Errors: %0d", err_cnt);
    if (err_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: list.f
+incdir+hdl
hdl/cce_pkg.sv
hdl/cce_inst_ram.sv
hdl/cce_inst_decode.sv
hdl/cce_exec.sv
hdl/cce_pending_bits.sv
hdl/cce_msg.sv
hdl/cce_top.sv
test/tb_cce.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_cce
FILELIST  ?= list.f
LOG       ?= sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): $(FILELIST) $(shell grep -v '^+' $(FILELIST)) hdl/cce_defs.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
